//--- run_sim.sh
#!/bin/sh
# Builds the tile bus testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_compute_tile_bus \
   -f sources.f --Mdir obj_dir -o tb_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "PASS: all tests" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- sim/tb_compute_tile_bus.sv
// Table-driven testbench for the compute tile bus with an adapter window slave model
module tb_compute_tile_bus;

   localparam int DM_AW          = 8;                        // DM word index bits
   localparam int N_ENTRIES      = 32;
   localparam int TIMEOUT_CYCLES = N_ENTRIES * 20 + 100;
   localparam int NAS_DELAY      = 3;                        // Model wait states
   localparam bit CORE = 1'b0, NA = 1'b1;
   localparam bit RD = 1'b0, WR = 1'b1;

   logic        clk, arst_n;
   logic [31:0] core_adr, core_wdat, core_rdat;
   logic [3:0]  core_sel;
   logic        core_we, core_cyc, core_stb, core_ack, core_err;
   logic [31:0] na_adr, na_wdat, na_rdat;
   logic [3:0]  na_sel;
   logic        na_we, na_cyc, na_stb, na_ack, na_err;
   logic [31:0] nas_adr, nas_wdat;
   logic [3:0]  nas_sel;
   logic        nas_we, nas_cyc, nas_stb;
   logic        nas_ack = 1'b0;
   logic        nas_err = 1'b0;
   logic [31:0] nas_rdat = '0;

   // Stimulus table with expected responses
   bit          t_na   [N_ENTRIES];
   bit          t_we   [N_ENTRIES];
   bit          t_par  [N_ENTRIES];   // Start together with the next entry
   bit          t_err  [N_ENTRIES];
   logic [31:0] t_adr  [N_ENTRIES];
   logic [31:0] t_dat  [N_ENTRIES];
   logic [31:0] t_rdat [N_ENTRIES];
   logic [3:0]  t_sel  [N_ENTRIES];
   int          n_built = 0;

   logic [31:0] dm_model [2**DM_AW];    // Shadow of DM contents
   integer      seed;
   int          errors = 0, tests = 0, failed = 0, cycles = 0;

   // Adapter window model state
   int          wait_cnt = 0;
   int          nas_hits = 0;           // Requests seen on the window
   logic [31:0] seen_adr, seen_dat;
   logic [3:0]  seen_sel;
   logic        seen_we;

   compute_tile_bus #(.DM_ADDR_WIDTH(DM_AW)) u_dut (
      .clk        (clk),       .arst_n_i   (arst_n),
      .core_adr_i (core_adr),  .core_dat_i (core_wdat), .core_sel_i (core_sel),
      .core_we_i  (core_we),   .core_cyc_i (core_cyc),  .core_stb_i (core_stb),
      .core_ack_o (core_ack),  .core_err_o (core_err),  .core_dat_o (core_rdat),
      .na_adr_i   (na_adr),    .na_dat_i   (na_wdat),   .na_sel_i   (na_sel),
      .na_we_i    (na_we),     .na_cyc_i   (na_cyc),    .na_stb_i   (na_stb),
      .na_ack_o   (na_ack),    .na_err_o   (na_err),    .na_dat_o   (na_rdat),
      .nas_adr_o  (nas_adr),   .nas_dat_o  (nas_wdat),  .nas_sel_o  (nas_sel),
      .nas_we_o   (nas_we),    .nas_cyc_o  (nas_cyc),   .nas_stb_o  (nas_stb),
      .nas_ack_i  (nas_ack),   .nas_err_i  (nas_err),   .nas_dat_i  (nas_rdat)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Window read data, a fixed scramble of the address
   function automatic logic [31:0] nas_word(input logic [31:0] adr);
      return {adr[15:0], ~adr[15:0]} ^ 32'h3c3c_0000;
   endfunction

   // Slave model on the adapter window, errors on offset bit 12
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         nas_ack  <= 1'b0;
         nas_err  <= 1'b0;
         wait_cnt <= 0;
      end else begin
         nas_ack <= 1'b0;  // One-cycle responses
         nas_err <= 1'b0;
         if (nas_cyc && nas_stb && !nas_ack && !nas_err) begin
            if (wait_cnt == 0)
               nas_hits <= nas_hits + 1;
            if (wait_cnt == NAS_DELAY) begin
               wait_cnt <= 0;
               seen_adr <= nas_adr;   // Last access seen
               seen_dat <= nas_wdat;
               seen_sel <= nas_sel;
               seen_we  <= nas_we;
               if (nas_adr[12]) begin
                  nas_err <= 1'b1;
               end else begin
                  nas_ack  <= 1'b1;
                  nas_rdat <= nas_word(nas_adr);
               end
            end else
               wait_cnt <= wait_cnt + 1;
         end
      end
   end

   // Appends one entry and works out its expected response from the memory map
   task automatic add_entry(input bit na, input bit we, input logic [31:0] adr,
                            input logic [3:0] sel, input bit par);
      logic [31:0]      wd;
      logic [DM_AW-1:0] dm_idx;
      logic [3:0]       rom_idx;
      logic [3:0]       rgn;
      wd      = we ? $random(seed) : 32'h0;
      rgn     = adr[31:28];
      dm_idx  = adr[DM_AW+1:2];            // Word index modulo DM depth
      rom_idx = adr[5:2];                  // Word index modulo ROM depth
      t_na[n_built]   = na;
      t_we[n_built]   = we;
      t_adr[n_built]  = adr;
      t_dat[n_built]  = wd;
      t_sel[n_built]  = sel;
      t_par[n_built]  = par;
      t_err[n_built]  = 1'b0;
      t_rdat[n_built] = '0;
      if (!rgn[3]) begin                   // DM
         if (we) begin
            for (int b = 0; b < 4; b++)
               if (sel[b])
                  dm_model[dm_idx][8*b +: 8] = wd[8*b +: 8];
         end else
            t_rdat[n_built] = dm_model[dm_idx];
      end else if (rgn == 4'hf) begin      // Boot ROM
         if (we)
            t_err[n_built] = 1'b1;
         else
            t_rdat[n_built] = tile_pkg::BOOT_ROM[rom_idx];
      end else if (rgn == 4'he) begin      // Adapter window
         if (adr[12])
            t_err[n_built] = 1'b1;
         else if (!we)
            t_rdat[n_built] = nas_word(adr);
      end else
         t_err[n_built] = 1'b1;            // Hole in the map
      n_built++;
   endtask

   task automatic build_table;
      add_entry(CORE, WR, 32'h0000_0010, 4'hf, 1'b0);  // Byte lane merge
      add_entry(CORE, WR, 32'h0000_0010, 4'h5, 1'b0);
      add_entry(CORE, RD, 32'h0000_0010, 4'hf, 1'b0);
      add_entry(CORE, WR, 32'h0000_0020, 4'hf, 1'b0);
      add_entry(CORE, WR, 32'h0000_0020, 4'h8, 1'b0);
      add_entry(CORE, RD, 32'h0000_0020, 4'hf, 1'b0);
      add_entry(CORE, WR, 32'h0000_0004, 4'hf, 1'b0);
      add_entry(CORE, WR, 32'h0000_03fc, 4'hf, 1'b0);
      add_entry(NA,   RD, 32'h0000_0404, 4'hf, 1'b0);  // Aliases index 1
      add_entry(NA,   RD, 32'h0000_0010, 4'hf, 1'b0);
      add_entry(NA,   RD, 32'h7fff_fffc, 4'hf, 1'b0);  // Aliases index 255
      add_entry(CORE, RD, 32'hf000_0000, 4'hf, 1'b0);  // Boot ROM
      add_entry(NA,   RD, 32'hf000_003c, 4'hf, 1'b0);
      add_entry(CORE, RD, 32'hf000_0044, 4'hf, 1'b0);  // Wraps to word 1
      add_entry(CORE, WR, 32'hf000_0008, 4'hf, 1'b0);
      add_entry(CORE, RD, 32'hf000_0008, 4'hf, 1'b0);
      add_entry(CORE, RD, 32'h8000_0000, 4'hf, 1'b0);  // Unmapped
      add_entry(NA,   WR, 32'h9000_0010, 4'hf, 1'b0);
      add_entry(CORE, WR, 32'hd000_fff0, 4'hf, 1'b0);
      add_entry(NA,   RD, 32'ha123_4560, 4'hf, 1'b0);
      add_entry(CORE, RD, 32'hc000_0000, 4'hf, 1'b0);
      add_entry(CORE, WR, 32'he000_0100, 4'h3, 1'b0);  // Adapter window
      add_entry(CORE, RD, 32'he000_0204, 4'hf, 1'b0);
      add_entry(NA,   RD, 32'he000_1008, 4'hf, 1'b0);
      add_entry(NA,   WR, 32'he000_0010, 4'hc, 1'b0);
      add_entry(CORE, WR, 32'h0000_0100, 4'hf, 1'b1);  // Contention pairs
      add_entry(NA,   WR, 32'h0000_0200, 4'hf, 1'b0);
      add_entry(CORE, RD, 32'h0000_0010, 4'hf, 1'b1);
      add_entry(NA,   WR, 32'h0000_0044, 4'hf, 1'b0);
      add_entry(CORE, RD, 32'h0000_0200, 4'hf, 1'b0);
      add_entry(NA,   RD, 32'h0000_0100, 4'hf, 1'b0);
      add_entry(CORE, RD, 32'h0000_0044, 4'hf, 1'b0);
   endtask

   // Puts entry i on its master's port, or idles that port
   task automatic drive_req(input int i, input bit on);
      if (!t_na[i]) begin
         core_adr  = on ? t_adr[i] : '0;
         core_wdat = on ? t_dat[i] : '0;
         core_sel  = on ? t_sel[i] : '0;
         core_we   = on & t_we[i];
         core_cyc  = on;
         core_stb  = on;
      end else begin
         na_adr  = on ? t_adr[i] : '0;
         na_wdat = on ? t_dat[i] : '0;
         na_sel  = on ? t_sel[i] : '0;
         na_we   = on & t_we[i];
         na_cyc  = on;
         na_stb  = on;
      end
   endtask

   task automatic run_entry(input int i);
      logic        ack, err;
      logic        late_ack, late_err;
      logic [31:0] rdat;
      int          waited, hits0, bad0;
      bit          to_na;
      string       who;
      who   = t_na[i] ? "na" : "core";
      to_na = (t_adr[i][31:28] == tile_pkg::REGION_NA);
      hits0 = nas_hits;
      bad0  = errors;
      @(negedge clk);
      drive_req(i, 1'b1);
      ack    = 1'b0;
      err    = 1'b0;
      rdat   = '0;
      waited = 0;
      while (!ack && !err) begin              // Global cycle counter bounds this
         @(negedge clk);
         waited++;
         ack  = t_na[i] ? na_ack  : core_ack;
         err  = t_na[i] ? na_err  : core_err;
         rdat = t_na[i] ? na_rdat : core_rdat;
      end
      // Request stays up over the response edge, it goes in the next cycle
      @(negedge clk);
      late_ack = t_na[i] ? na_ack : core_ack;
      late_err = t_na[i] ? na_err : core_err;
      drive_req(i, 1'b0);
      if (err !== t_err[i]) begin
         $display("[FAIL] test %0d %s_err_o exp %h got %h", i, who, t_err[i], err);
         errors++;
      end
      if (ack !== !t_err[i]) begin
         $display("[FAIL] test %0d %s_ack_o exp %h got %h", i, who, !t_err[i], ack);
         errors++;
      end
      if (late_ack !== 1'b0 || late_err !== 1'b0) begin
         $display("[FAIL] test %0d %s_ack_o/%s_err_o one cycle later exp 0/0 got %h/%h",
                  i, who, who, late_ack, late_err);
         errors++;
      end
      if (!t_err[i] && !t_we[i] && rdat !== t_rdat[i]) begin
         $display("[FAIL] test %0d %s_dat_o exp %h got %h", i, who, t_rdat[i], rdat);
         errors++;
      end
      if (!t_par[i] && !(i > 0 && t_par[i-1]) && !to_na && waited != 2) begin
         $display("test %0d: transfer ended after %0d cycles instead of 2", i, waited);
         errors++;
      end
      if (to_na) begin
         if (nas_hits != hits0 + 1) begin
            $display("test %0d: the access never reached the adapter window", i);
            errors++;
         end else begin
            if (seen_adr !== t_adr[i]) begin
               $display("[FAIL] test %0d nas_adr_o exp %h got %h", i, t_adr[i], seen_adr);
               errors++;
            end
            if (seen_we !== t_we[i] || seen_sel !== t_sel[i]) begin
               $display("[FAIL] test %0d nas_we_o/nas_sel_o exp %h/%h got %h/%h",
                        i, t_we[i], t_sel[i], seen_we, seen_sel);
               errors++;
            end
            if (t_we[i] && seen_dat !== t_dat[i]) begin
               $display("[FAIL] test %0d nas_dat_o exp %h got %h", i, t_dat[i], seen_dat);
               errors++;
            end
         end
      end else if (nas_hits != hits0) begin
         $display("test %0d: the access leaked onto the adapter window", i);
         errors++;
      end
      tests++;
      if (errors != bad0)
         failed++;
      $display("test %0d %s %s 0x%h sel %h after %0d cycles: %s", i, who,
               t_we[i] ? "wr" : "rd", t_adr[i], t_sel[i], waited,
               (errors == bad0) ? "ok" : "bad");
   endtask

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, a transfer never ended", cycles);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial begin
      int i;
      seed      = 32'h27a8_6d9d;
      arst_n    = 1'b0;
      core_adr  = '0;
      core_wdat = '0;
      core_sel  = '0;
      core_we   = 1'b0;
      core_cyc  = 1'b0;
      core_stb  = 1'b0;
      na_adr    = '0;
      na_wdat   = '0;
      na_sel    = '0;
      na_we     = 1'b0;
      na_cyc    = 1'b0;
      na_stb    = 1'b0;
      build_table();
      repeat (3) @(negedge clk);
      arst_n = 1'b1;
      i = 0;
      while (i < n_built) begin
         if (t_par[i]) begin
            fork                            // Both masters in the same cycle
               run_entry(i);
               run_entry(i + 1);
            join
            i += 2;
         end else begin
            run_entry(i);
            i++;
         end
      end
      repeat (2) @(negedge clk);
      $display("tests run %0d, tests failed %0d, check errors %0d", tests, failed, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- source/compute_tile_bus.sv
// Compute tile bus with two masters, data memory, boot ROM and an exported adapter window
module compute_tile_bus #(
   parameter int DM_ADDR_WIDTH = 8
) (
   input  logic                            clk,
   input  logic                            arst_n_i,
   // Core master port
   input  logic [tile_pkg::ADDR_WIDTH-1:0] core_adr_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] core_dat_i,
   input  logic [tile_pkg::SEL_WIDTH-1:0]  core_sel_i,
   input  logic                            core_we_i,
   input  logic                            core_cyc_i,
   input  logic                            core_stb_i,
   output logic                            core_ack_o,
   output logic                            core_err_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] core_dat_o,
   // Adapter master port
   input  logic [tile_pkg::ADDR_WIDTH-1:0] na_adr_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] na_dat_i,
   input  logic [tile_pkg::SEL_WIDTH-1:0]  na_sel_i,
   input  logic                            na_we_i,
   input  logic                            na_cyc_i,
   input  logic                            na_stb_i,
   output logic                            na_ack_o,
   output logic                            na_err_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] na_dat_o,
   // Adapter window, slave side
   output logic [tile_pkg::ADDR_WIDTH-1:0] nas_adr_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] nas_dat_o,
   output logic [tile_pkg::SEL_WIDTH-1:0]  nas_sel_o,
   output logic                            nas_we_o,
   output logic                            nas_cyc_o,
   output logic                            nas_stb_o,
   input  logic                            nas_ack_i,
   input  logic                            nas_err_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] nas_dat_i
);

   logic [tile_pkg::ADDR_WIDTH-1:0] bus_adr;
   logic [tile_pkg::DATA_WIDTH-1:0] bus_dat, bus_rdat;
   logic [tile_pkg::SEL_WIDTH-1:0]  bus_sel;
   logic                            bus_we, bus_cyc, bus_stb, bus_ack, bus_err;
   logic [tile_pkg::NR_SLAVES-1:0]  slv_stb, slv_ack, slv_err;
   logic [tile_pkg::DATA_WIDTH-1:0] dm_rdat, boot_rdat;

   tile_bus_arbiter u_arbiter (
      .clk        (clk),        .arst_n_i   (arst_n_i),
      .core_adr_i (core_adr_i), .core_dat_i (core_dat_i), .core_sel_i (core_sel_i),
      .core_we_i  (core_we_i),  .core_cyc_i (core_cyc_i), .core_stb_i (core_stb_i),
      .na_adr_i   (na_adr_i),   .na_dat_i   (na_dat_i),   .na_sel_i   (na_sel_i),
      .na_we_i    (na_we_i),    .na_cyc_i   (na_cyc_i),   .na_stb_i   (na_stb_i),
      .bus_adr_o  (bus_adr),    .bus_dat_o  (bus_dat),    .bus_sel_o  (bus_sel),
      .bus_we_o   (bus_we),     .bus_cyc_o  (bus_cyc),    .bus_stb_o  (bus_stb),
      .bus_ack_i  (bus_ack),    .bus_err_i  (bus_err),    .bus_rdat_i (bus_rdat),
      .core_ack_o (core_ack_o), .core_err_o (core_err_o), .core_dat_o (core_dat_o),
      .na_ack_o   (na_ack_o),   .na_err_o   (na_err_o),   .na_dat_o   (na_dat_o)
   );

   tile_addr_decode u_decode (
      .clk         (clk),       .arst_n_i  (arst_n_i),
      .bus_adr_i   (bus_adr),   .bus_we_i  (bus_we),
      .bus_cyc_i   (bus_cyc),   .bus_stb_i (bus_stb),
      .slv_stb_o   (slv_stb),   .slv_ack_i (slv_ack), .slv_err_i (slv_err),
      .dm_rdat_i   (dm_rdat),   .na_rdat_i (nas_dat_i),
      .boot_rdat_i (boot_rdat),
      .bus_ack_o   (bus_ack),   .bus_err_o (bus_err), .bus_rdat_o (bus_rdat)
   );

   tile_dm_sram #(
      .DM_ADDR_WIDTH (DM_ADDR_WIDTH)
   ) u_dm (
      .clk   (clk),                        .arst_n_i (arst_n_i),
      .stb_i (slv_stb[tile_pkg::SLAVE_DM]), .we_i    (bus_we),
      .adr_i (bus_adr),                     .dat_i    (bus_dat),
      .sel_i (bus_sel),
      .ack_o (slv_ack[tile_pkg::SLAVE_DM]), .dat_o    (dm_rdat)
   );
   assign slv_err[tile_pkg::SLAVE_DM] = 1'b0;  // DM never fails

   tile_bootrom u_boot (
      .clk   (clk),                           .arst_n_i (arst_n_i),
      .stb_i (slv_stb[tile_pkg::SLAVE_BOOT]), .we_i     (bus_we),
      .adr_i (bus_adr),
      .ack_o (slv_ack[tile_pkg::SLAVE_BOOT]), .err_o    (slv_err[tile_pkg::SLAVE_BOOT]),
      .dat_o (boot_rdat)
   );

   // Adapter window goes straight out of the tile
   assign nas_stb_o = slv_stb[tile_pkg::SLAVE_NA];
   assign nas_adr_o = bus_adr;
   assign nas_dat_o = bus_dat;
   assign nas_sel_o = bus_sel;
   assign nas_we_o  = bus_we;
   assign nas_cyc_o = bus_cyc;  // Shared cyc, stb qualifies
   assign slv_ack[tile_pkg::SLAVE_NA] = nas_ack_i;
   assign slv_err[tile_pkg::SLAVE_NA] = nas_err_i;

endmodule

//--- source/tile_addr_decode.sv
// Address decoder routing bus strobes by region and muxing slave responses back
module tile_addr_decode (
   input  logic                            clk,
   input  logic                            arst_n_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0] bus_adr_i,
   input  logic                            bus_we_i,
   input  logic                            bus_cyc_i,
   input  logic                            bus_stb_i,
   output logic [tile_pkg::NR_SLAVES-1:0]  slv_stb_o,
   input  logic [tile_pkg::NR_SLAVES-1:0]  slv_ack_i,
   input  logic [tile_pkg::NR_SLAVES-1:0]  slv_err_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] dm_rdat_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] na_rdat_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] boot_rdat_i,
   output logic                            bus_ack_o,
   output logic                            bus_err_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] bus_rdat_o
);

   tile_pkg::tile_addr_t                 adr_u;
   logic [tile_pkg::NR_SLAVES-1:0] sel_d, sel_q;
   logic                           stb_v;
   logic                           unmapped;
   logic                           err_q;  // Decoder's own error for holes

   assign adr_u = bus_adr_i;
   assign stb_v = bus_stb_i & bus_cyc_i;

   always_comb begin
      sel_d = '0;
      if (!adr_u.rgn.region[3])
         sel_d[tile_pkg::SLAVE_DM] = 1'b1;              // Lower half of the map
      else if (adr_u.rgn.region == tile_pkg::REGION_NA)
         sel_d[tile_pkg::SLAVE_NA] = 1'b1;
      else if (adr_u.rgn.region == tile_pkg::REGION_BOOT)
         sel_d[tile_pkg::SLAVE_BOOT] = 1'b1;
   end

   assign unmapped  = (sel_d == '0);
   assign slv_stb_o = stb_v ? sel_d : '0;  // Only the selected slave sees stb

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sel_q <= '0;
         err_q <= 1'b0;
      end else begin
         sel_q <= stb_v ? sel_d : '0;                // Select used for responses
         err_q <= stb_v & unmapped & ~err_q;         // One pulse per request
      end
   end

   // Response mux
   assign bus_ack_o = |(slv_ack_i & sel_q);
   assign bus_err_o = err_q | |(slv_err_i & sel_q);

   always_comb begin
      bus_rdat_o = '0;
      if (sel_q[tile_pkg::SLAVE_DM])
         bus_rdat_o = dm_rdat_i;
      else if (sel_q[tile_pkg::SLAVE_NA])
         bus_rdat_o = na_rdat_i;
      else if (sel_q[tile_pkg::SLAVE_BOOT])
         bus_rdat_o = boot_rdat_i;
   end

   a_ack_err_excl : assert property (@(posedge clk) disable iff (!arst_n_i)
      !(bus_ack_o && bus_err_o)) else $error("Ack and err together");

   a_stb_onehot : assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0(slv_stb_o)) else $error("More than one slave strobed");

   // ROM must refuse writes on the next cycle
   a_boot_write_err : assert property (@(posedge clk) disable iff (!arst_n_i)
      slv_stb_o[tile_pkg::SLAVE_BOOT] && bus_we_i && !bus_err_o |=> !bus_ack_o)
      else $error("Write to boot ROM acknowledged");

endmodule

//--- source/tile_bootrom.sv
// Boot ROM slave returning a constant table and answering writes with err
module tile_bootrom (
   input  logic                            clk,
   input  logic                            arst_n_i,
   input  logic                            stb_i,
   input  logic                            we_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0] adr_i,
   output logic                            ack_o,
   output logic                            err_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] dat_o
);

   localparam int IDX_WIDTH = $clog2(tile_pkg::ROM_WORDS);

   tile_pkg::tile_addr_t  adr_u;
   logic [IDX_WIDTH-1:0] idx;
   logic                 ack_q, err_q;
   logic                 access;

   assign adr_u  = adr_i;
   assign idx    = adr_u.word.index[IDX_WIDTH-1:0];  // Wraps at table depth
   assign access = stb_i & ~(ack_q | err_q);         // Skip the response cycle

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= access & ~we_i;
         err_q <= access & we_i;  // Read only
      end
   end

   always_ff @(posedge clk) begin
      if (access)
         dat_o <= tile_pkg::BOOT_ROM[idx];
   end

   assign ack_o = ack_q;
   assign err_o = err_q;

endmodule

//--- source/tile_bus_arbiter.sv
// Round-robin arbiter granting the shared tile bus to the core or the network adapter master
module tile_bus_arbiter (
   input  logic                            clk,
   input  logic                            arst_n_i,
   // Core master
   input  logic [tile_pkg::ADDR_WIDTH-1:0] core_adr_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] core_dat_i,
   input  logic [tile_pkg::SEL_WIDTH-1:0]  core_sel_i,
   input  logic                            core_we_i,
   input  logic                            core_cyc_i,
   input  logic                            core_stb_i,
   // Adapter master
   input  logic [tile_pkg::ADDR_WIDTH-1:0] na_adr_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] na_dat_i,
   input  logic [tile_pkg::SEL_WIDTH-1:0]  na_sel_i,
   input  logic                            na_we_i,
   input  logic                            na_cyc_i,
   input  logic                            na_stb_i,
   // Shared bus
   output logic [tile_pkg::ADDR_WIDTH-1:0] bus_adr_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] bus_dat_o,
   output logic [tile_pkg::SEL_WIDTH-1:0]  bus_sel_o,
   output logic                            bus_we_o,
   output logic                            bus_cyc_o,
   output logic                            bus_stb_o,
   input  logic                            bus_ack_i,
   input  logic                            bus_err_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] bus_rdat_i,
   // Responses back to the masters
   output logic                            core_ack_o,
   output logic                            core_err_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] core_dat_o,
   output logic                            na_ack_o,
   output logic                            na_err_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] na_dat_o
);

   logic [1:0] gnt_q, gnt_d;  // Bit 0 core, bit 1 adapter
   logic       last_q;        // Set when the adapter won last
   logic       hold;

   // Granted master keeps the bus while its cyc stays high
   assign hold = (gnt_q[0] & core_cyc_i) | (gnt_q[1] & na_cyc_i);

   always_comb begin
      gnt_d = gnt_q;
      if (!hold) begin
         gnt_d = 2'b00;                              // Idle unless someone asks
         if (core_cyc_i && na_cyc_i)
            gnt_d = last_q ? 2'b01 : 2'b10;          // Other one's turn
         else if (core_cyc_i)
            gnt_d = 2'b01;
         else if (na_cyc_i)
            gnt_d = 2'b10;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         gnt_q  <= 2'b00;
         last_q <= 1'b0;
      end else begin
         gnt_q <= gnt_d;
         if (gnt_d != 2'b00)
            last_q <= gnt_d[1];  // Remember winner for round-robin
      end
   end

   // Request mux, core is the default path
   assign bus_adr_o = gnt_q[1] ? na_adr_i : core_adr_i;
   assign bus_dat_o = gnt_q[1] ? na_dat_i : core_dat_i;
   assign bus_sel_o = gnt_q[1] ? na_sel_i : core_sel_i;
   assign bus_we_o  = gnt_q[1] ? na_we_i  : core_we_i;
   assign bus_cyc_o = hold;
   assign bus_stb_o = (gnt_q[0] & core_cyc_i & core_stb_i) | (gnt_q[1] & na_cyc_i & na_stb_i);

   // Steer responses only to the owner
   assign core_ack_o = bus_ack_i & gnt_q[0];
   assign core_err_o = bus_err_i & gnt_q[0];
   assign core_dat_o = gnt_q[0] ? bus_rdat_i : '0;
   assign na_ack_o   = bus_ack_i & gnt_q[1];
   assign na_err_o   = bus_err_i & gnt_q[1];
   assign na_dat_o   = gnt_q[1] ? bus_rdat_i : '0;

   a_gnt_onehot : assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0(gnt_q)) else $error("Both masters granted");

   // An ack ends a cycle the master opened at least one cycle earlier
   a_core_ack_owner : assert property (@(posedge clk) disable iff (!arst_n_i)
      core_ack_o |-> core_cyc_i && $past(core_cyc_i) && $past(gnt_d[0]))
      else $error("Ack to ungranted core");
   a_na_ack_owner : assert property (@(posedge clk) disable iff (!arst_n_i)
      na_ack_o |-> na_cyc_i && $past(na_cyc_i) && $past(gnt_d[1]))
      else $error("Ack to ungranted adapter");

endmodule

//--- source/tile_dm_sram.sv
// Single-port data memory slave with byte selects and one-cycle ack
module tile_dm_sram #(
   parameter int DM_ADDR_WIDTH = 8  // Word index bits
) (
   input  logic                            clk,
   input  logic                            arst_n_i,
   input  logic                            stb_i,
   input  logic                            we_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0] adr_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] dat_i,
   input  logic [tile_pkg::SEL_WIDTH-1:0]  sel_i,
   output logic                            ack_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] dat_o
);

   localparam int DEPTH = 2 ** DM_ADDR_WIDTH;

   logic [tile_pkg::DATA_WIDTH-1:0] mem [DEPTH];
   tile_pkg::tile_addr_t            adr_u;
   logic [DM_ADDR_WIDTH-1:0]        idx;
   logic                            ack_q;
   logic                            access;

   assign adr_u = adr_i;
   assign idx   = adr_u.word.index[DM_ADDR_WIDTH-1:0];  // Upper bits alias
   // No new access in the ack cycle, held stb must not hit twice
   assign access = stb_i & ~ack_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i)
         ack_q <= 1'b0;
      else
         ack_q <= access;
   end

   // Storage and read data
   always_ff @(posedge clk) begin
      if (access) begin
         if (we_i) begin
            for (int b = 0; b < tile_pkg::SEL_WIDTH; b++) begin
               if (sel_i[b])
                  mem[idx][8*b +: 8] <= dat_i[8*b +: 8];  // Selected lanes only
            end
         end
         dat_o <= mem[idx];  // Old word on a write, nobody reads it
      end
   end

   assign ack_o = ack_q;

   a_ack_after_stb : assert property (@(posedge clk) disable iff (!arst_n_i)
      $rose(ack_o) |-> $past(stb_i)) else $error("DM ack without stb");

endmodule

//--- source/tile_pkg.sv
// Tile bus package with widths, region codes, slave indices, address views and boot table
package tile_pkg;

   localparam int ADDR_WIDTH = 32;  // One bus word
   localparam int DATA_WIDTH = 32;
   localparam int SEL_WIDTH  = 4;   // Byte selects per word

   localparam int NR_SLAVES  = 3;   // Routed slaves behind the decoder
   localparam int SLAVE_DM   = 0;   // Bit positions in one-hot select vectors
   localparam int SLAVE_NA   = 1;
   localparam int SLAVE_BOOT = 2;

   localparam logic [3:0] REGION_NA   = 4'he;  // Adapter window nibble
   localparam logic [3:0] REGION_BOOT = 4'hf;  // Boot ROM nibble

   // Decoder view of an address
   typedef struct packed {
      logic [3:0]  region;  // Top nibble picks the slave
      logic [27:0] offset;
   } tile_rgn_view_t;

   // Memory view of the same address
   typedef struct packed {
      logic [29:0] index;     // Word index
      logic [1:0]  byte_off;  // Byte within word, covered by sel
   } tile_word_view_t;

   typedef union packed {
      tile_rgn_view_t  rgn;
      tile_word_view_t word;
   } tile_addr_t;

   localparam int ROM_WORDS = 16;  // Boot table depth

   // Small boot stub, jumps into DM after setting up sp
   localparam logic [DATA_WIDTH-1:0] BOOT_ROM [ROM_WORDS] = '{
      32'h0000_0093, 32'h0000_0113, 32'h0000_0193, 32'h0000_0213,
      32'h0001_0137, 32'hff01_0113, 32'he000_02b7, 32'h0002_a303,
      32'h0003_0663, 32'h0000_0313, 32'h0000_03b7, 32'h0003_8067,
      32'h1050_0073, 32'hffdf_f06f, 32'h0000_0013, 32'hdead_beef
   };

endpackage

//--- sources.f
source/tile_pkg.sv
source/tile_bus_arbiter.sv
source/tile_addr_decode.sv
source/tile_dm_sram.sv
source/tile_bootrom.sv
source/compute_tile_bus.sv
sim/tb_compute_tile_bus.sv
